//--- Makefile
# Verilator build and run for the board controller testbench

VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FILELIST  ?= board_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- board_ctrl.f
+incdir+src
src/board_bus_pkg.sv
src/board_io_pkg.sv
src/epb_wb_bridge.sv
src/system_block.sv
src/misc_regs.sv
src/reset_boot_ctrl.sv
src/board_ctrl_top.sv
tests/board_ctrl_tb.sv

//--- src/board_bus_pkg.sv
package board_bus_pkg;

  // ************************************************
  // register bus widths
  // ************************************************

  // full epb address as seen by the bridge
  typedef logic [4:0] epb_addr_t;

  // register index inside one slave
  typedef logic [2:0] reg_addr_t;

  typedef logic [7:0] bus_data_t;

  // upper address bits that pick a slave
  typedef logic [1:0] slave_sel_t;

  // bridge sequencing for one epb access
  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_ready,
    st_release
  } bridge_state_t;

endpackage

//--- src/board_ctrl_macros.svh
`ifndef BOARD_CTRL_MACROS_SVH
`define BOARD_CTRL_MACROS_SVH

// ************************************************
// design identity and revision
// ************************************************

// read back as two bytes through the system block
`define DESIGN_ID 16'hb0c7

`define REV_MAJOR 8'd1
`define REV_MINOR 8'd3
`define REV_RCS   8'd0

// ************************************************
// boot mode selection
// ************************************************

// boot codes driven onto boot_conf
`define BOOT_CODE_DIP    3'b001
`define BOOT_CODE_FAST   3'b010
`define BOOT_CODE_EEPROM 3'b111

// set one of these to 1 to override the dip based boot decode
// eeprom boot reads its configuration from i2c address 0xa4
`define BOOT_CONF_EEPROM 1'b0
`define BOOT_CONF_FAST   1'b0

`endif

//--- src/board_ctrl_top.sv
`timescale 1ns/100ps

module board_ctrl_top
  import board_bus_pkg::*, board_io_pkg::*;
(
  input  logic       clk_master,
  input  logic       sys_reset,
  input  logic       epb_cs_n_i,
  input  logic       epb_oe_n_i,
  input  logic       epb_we_n_i,
  input  epb_addr_t  epb_addr_i,
  input  bus_data_t  epb_data_i,
  output bus_data_t  epb_data_o,
  output logic       epb_data_oe_o,
  output logic       epb_rdy_o,
  input  irq_vec_t   irq_src_i,
  output logic       ppc_irq_n_o,
  input  strap_t     sys_config_i,
  input  dip_t       user_dip_i,
  input  dip_t       config_dip_i,
  input  logic       flash_busy_n_i,
  input  logic       reset_debug_n_i,
  output led_t       user_led_n_o,
  output logic       ppc_reset_n_o,
  output logic       ppc_ddr2_reset_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_oe_o,
  output boot_conf_t boot_conf_o,
  output logic       eeprom_wp_o
);

  // ************************************************
  // register bus
  // ************************************************

  logic      reg_we;
  reg_addr_t reg_adr;
  bus_data_t reg_wdat;
  logic      stb_misc;
  logic      stb_sys;
  bus_data_t rdat_misc;
  bus_data_t rdat_sys;
  logic      ack_misc;
  logic      ack_sys;

  // misc register bits that drive the reset block
  logic por_force_req;
  logic geth_reset_req;

  epb_wb_bridge u_bridge (
    .clk_master    (clk_master),
    .sys_reset     (sys_reset),
    .epb_cs_n_i    (epb_cs_n_i),
    .epb_oe_n_i    (epb_oe_n_i),
    .epb_we_n_i    (epb_we_n_i),
    .epb_addr_i    (epb_addr_i),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_o (epb_data_oe_o),
    .epb_rdy_o     (epb_rdy_o),
    .reg_we_o      (reg_we),
    .reg_adr_o     (reg_adr),
    .reg_wdat_o    (reg_wdat),
    .stb_misc_o    (stb_misc),
    .stb_sys_o     (stb_sys),
    .rdat_misc_i   (rdat_misc),
    .ack_misc_i    (ack_misc),
    .rdat_sys_i    (rdat_sys),
    .ack_sys_i     (ack_sys)
  );

  system_block u_system (
    .clk_master  (clk_master),
    .sys_reset   (sys_reset),
    .stb_i       (stb_sys),
    .we_i        (reg_we),
    .adr_i       (reg_adr),
    .wdat_i      (reg_wdat),
    .rdat_o      (rdat_sys),
    .ack_o       (ack_sys),
    .irq_src_i   (irq_src_i),
    .ppc_irq_n_o (ppc_irq_n_o)
  );

  misc_regs u_misc (
    .clk_master       (clk_master),
    .sys_reset        (sys_reset),
    .stb_i            (stb_misc),
    .we_i             (reg_we),
    .adr_i            (reg_adr),
    .wdat_i           (reg_wdat),
    .rdat_o           (rdat_misc),
    .ack_o            (ack_misc),
    .sys_config_i     (sys_config_i),
    .user_dip_i       (user_dip_i),
    .config_dip_i     (config_dip_i),
    .flash_busy_n_i   (flash_busy_n_i),
    .por_force_req_o  (por_force_req),
    .geth_reset_req_o (geth_reset_req),
    .user_led_n_o     (user_led_n_o)
  );

  // ************************************************
  // resets and boot
  // ************************************************

  reset_boot_ctrl u_reset_boot (
    .clk_master         (clk_master),
    .sys_reset          (sys_reset),
    .reset_debug_n_i    (reset_debug_n_i),
    .por_force_req_i    (por_force_req),
    .geth_reset_req_i   (geth_reset_req),
    .sys_config_i       (sys_config_i),
    .user_dip_i         (user_dip_i),
    .config_dip_i       (config_dip_i),
    .ppc_reset_n_o      (ppc_reset_n_o),
    .ppc_ddr2_reset_n_o (ppc_ddr2_reset_n_o),
    .geth_reset_n_o     (geth_reset_n_o),
    .por_force_oe_o     (por_force_oe_o),
    .boot_conf_o        (boot_conf_o),
    .eeprom_wp_o        (eeprom_wp_o)
  );

endmodule

//--- src/board_io_pkg.sv
package board_io_pkg;

  // interrupt sources feeding the system block
  typedef logic [3:0] irq_vec_t;

  typedef logic [1:0] led_t;

  // one bank of dip switches
  typedef logic [3:0] dip_t;

  // sys_config board straps
  typedef logic [7:0] strap_t;

  // boot configuration code presented to the processor
  typedef logic [2:0] boot_conf_t;

endpackage

//--- src/epb_wb_bridge.sv
`timescale 1ns/100ps

module epb_wb_bridge
  import board_bus_pkg::*;
(
  input  logic      clk_master,
  input  logic      sys_reset,
  input  logic      epb_cs_n_i,
  input  logic      epb_oe_n_i,
  input  logic      epb_we_n_i,
  input  epb_addr_t epb_addr_i,
  input  bus_data_t epb_data_i,
  output bus_data_t epb_data_o,
  output logic      epb_data_oe_o,
  output logic      epb_rdy_o,
  output logic      reg_we_o,
  output reg_addr_t reg_adr_o,
  output bus_data_t reg_wdat_o,
  output logic      stb_misc_o,
  output logic      stb_sys_o,
  input  bus_data_t rdat_misc_i,
  input  logic      ack_misc_i,
  input  bus_data_t rdat_sys_i,
  input  logic      ack_sys_i
);

  localparam slave_sel_t sel_misc = 2'b00;
  localparam slave_sel_t sel_sys  = 2'b11;

  bridge_state_t state;
  epb_addr_t     addr_q;
  bus_data_t     wdat_q;
  logic          wr_q;
  logic          rd_q;
  logic          unmap_ack;
  logic          bus_ack;
  logic          mapped;
  slave_sel_t    sel;
  bus_data_t     rdat_mux;

  assign sel     = addr_q[4:3];
  assign mapped  = (sel == sel_misc) || (sel == sel_sys);
  assign bus_ack = ack_misc_i | ack_sys_i | unmap_ack;

  assign reg_we_o   = wr_q;
  assign reg_adr_o  = addr_q[2:0];
  assign reg_wdat_o = wdat_q;

  // unmapped slaves return zero
  always_comb begin
    case (sel)
      sel_misc: rdat_mux = rdat_misc_i;
      sel_sys:  rdat_mux = rdat_sys_i;
      default:  rdat_mux = '0;
    endcase
  end

  // address and write data are held for the whole access
  always_ff @(posedge clk_master) begin
    if (state == st_idle && !epb_cs_n_i) begin
      addr_q <= epb_addr_i;
      wdat_q <= epb_data_i;
    end
    if (state == st_access && bus_ack && rd_q) begin
      epb_data_o <= rdat_mux;
    end
  end

  // ************************************************
  // access sequencing
  // ************************************************

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      state         <= st_idle;
      wr_q          <= 1'b0;
      rd_q          <= 1'b0;
      stb_misc_o    <= 1'b0;
      stb_sys_o     <= 1'b0;
      unmap_ack     <= 1'b0;
      epb_rdy_o     <= 1'b0;
      epb_data_oe_o <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!epb_cs_n_i) begin
            state      <= st_access;
            wr_q       <= !epb_we_n_i;
            rd_q       <= epb_we_n_i && !epb_oe_n_i;
            stb_misc_o <= (epb_addr_i[4:3] == sel_misc);
            stb_sys_o  <= (epb_addr_i[4:3] == sel_sys);
          end
        end
        st_access: begin
          // an unmapped access answers itself with the same latency as a slave
          unmap_ack <= !mapped && !unmap_ack;
          if (bus_ack) begin
            state         <= st_ready;
            stb_misc_o    <= 1'b0;
            stb_sys_o     <= 1'b0;
            epb_rdy_o     <= 1'b1;
            epb_data_oe_o <= rd_q;
          end
        end
        st_ready: begin
          // the host holds chip select for as long as it needs the data
          if (epb_cs_n_i) begin
            state         <= st_release;
            wr_q          <= 1'b0;
            epb_rdy_o     <= 1'b0;
            epb_data_oe_o <= 1'b0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- src/misc_regs.sv
`timescale 1ns/100ps

module misc_regs
  import board_bus_pkg::*, board_io_pkg::*;
(
  input  logic      clk_master,
  input  logic      sys_reset,
  input  logic      stb_i,
  input  logic      we_i,
  input  reg_addr_t adr_i,
  input  bus_data_t wdat_i,
  output bus_data_t rdat_o,
  output logic      ack_o,
  input  strap_t    sys_config_i,
  input  dip_t      user_dip_i,
  input  dip_t      config_dip_i,
  input  logic      flash_busy_n_i,
  output logic      por_force_req_o,
  output logic      geth_reset_req_o,
  output led_t      user_led_n_o
);

  logic wr_en;
  logic por_force_q;
  logic geth_reset_q;
  led_t user_led_q;

  assign wr_en = stb_i && we_i && !ack_o;

  assign por_force_req_o  = por_force_q;
  assign geth_reset_req_o = geth_reset_q;

  // the leds are driven low to light up
  assign user_led_n_o = ~user_led_q;

  // ************************************************
  // control registers
  // ************************************************

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      ack_o        <= 1'b0;
      por_force_q  <= 1'b0;
      geth_reset_q <= 1'b0;
      user_led_q   <= '0;
    end else begin
      ack_o <= stb_i && !ack_o;
      if (wr_en) begin
        case (adr_i)
          3'd0:    por_force_q  <= wdat_i[0];
          3'd1:    geth_reset_q <= wdat_i[0];
          3'd2:    user_led_q   <= wdat_i[1:0];
          default: ;
        endcase
      end
    end
  end

  // ************************************************
  // read map
  // ************************************************

  // writes to the status registers 3 to 7 are ignored
  always_comb begin
    case (adr_i)
      3'd0:    rdat_o = {7'b0000000, por_force_q};
      3'd1:    rdat_o = {7'b0000000, geth_reset_q};
      3'd2:    rdat_o = {6'b000000, user_led_q};
      3'd3:    rdat_o = sys_config_i;
      3'd4:    rdat_o = {user_dip_i, config_dip_i};
      3'd5:    rdat_o = {7'b0000000, flash_busy_n_i};
      default: rdat_o = '0;
    endcase
  end

endmodule

//--- src/reset_boot_ctrl.sv
`timescale 1ns/100ps
`include "board_ctrl_macros.svh"

module reset_boot_ctrl
  import board_io_pkg::*;
(
  input  logic       clk_master,
  input  logic       sys_reset,
  input  logic       reset_debug_n_i,
  input  logic       por_force_req_i,
  input  logic       geth_reset_req_i,
  input  strap_t     sys_config_i,
  input  dip_t       user_dip_i,
  input  dip_t       config_dip_i,
  output logic       ppc_reset_n_o,
  output logic       ppc_ddr2_reset_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_oe_o,
  output boot_conf_t boot_conf_o,
  output logic       eeprom_wp_o
);

  logic       por_req_prev;
  boot_conf_t boot_dip;

  // the debug header can hold the processor alone in reset
  assign ppc_reset_n_o      = reset_debug_n_i && !sys_reset;
  assign ppc_ddr2_reset_n_o = !sys_reset;
  assign geth_reset_n_o     = !sys_reset && !geth_reset_req_i;

  // once fired the power on reset force stays on until the next system reset
  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      por_req_prev   <= 1'b0;
      por_force_oe_o <= 1'b0;
    end else begin
      por_req_prev <= por_force_req_i;
      if (por_force_req_i && !por_req_prev) begin
        por_force_oe_o <= 1'b1;
      end
    end
  end

  // ************************************************
  // boot configuration
  // ************************************************

  // first match wins
  assign boot_dip = !config_dip_i[1] ? `BOOT_CODE_DIP :
                    !config_dip_i[0] ? `BOOT_CODE_FAST :
                    sys_config_i[1]  ? `BOOT_CODE_EEPROM :
                                       `BOOT_CODE_FAST;

  assign boot_conf_o = `BOOT_CONF_EEPROM ? `BOOT_CODE_EEPROM :
                       `BOOT_CONF_FAST   ? `BOOT_CODE_FAST :
                                           boot_dip;

  assign eeprom_wp_o = !user_dip_i[3];

endmodule

//--- src/system_block.sv
`timescale 1ns/100ps
`include "board_ctrl_macros.svh"

module system_block
  import board_bus_pkg::*, board_io_pkg::*;
(
  input  logic      clk_master,
  input  logic      sys_reset,
  input  logic      stb_i,
  input  logic      we_i,
  input  reg_addr_t adr_i,
  input  bus_data_t wdat_i,
  output bus_data_t rdat_o,
  output logic      ack_o,
  input  irq_vec_t  irq_src_i,
  output logic      ppc_irq_n_o
);

  localparam logic [15:0] design_id = `DESIGN_ID;

  irq_vec_t  irq_prev;
  irq_vec_t  irq_edge;
  irq_vec_t  irq_status;
  irq_vec_t  irq_mask;
  irq_vec_t  irq_clear;
  bus_data_t scratch;
  logic      wr_en;

  // a write lands in the same edge that raises ack
  assign wr_en = stb_i && we_i && !ack_o;

  assign irq_edge  = irq_src_i & ~irq_prev;
  assign irq_clear = (wr_en && adr_i == 3'd5) ? wdat_i[3:0] : '0;

  // request is active low while any unmasked status bit is set
  assign ppc_irq_n_o = ~|(irq_status & irq_mask);

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      ack_o      <= 1'b0;
      irq_prev   <= '0;
      irq_status <= '0;
      irq_mask   <= '0;
    end else begin
      ack_o    <= stb_i && !ack_o;
      irq_prev <= irq_src_i;
      // a fresh edge beats a clear in the same cycle
      irq_status <= (irq_status & ~irq_clear) | irq_edge;
      if (wr_en && adr_i == 3'd6) begin
        irq_mask <= wdat_i[3:0];
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (wr_en && adr_i == 3'd7) begin
      scratch <= wdat_i;
    end
  end

  // ************************************************
  // read map
  // ************************************************

  always_comb begin
    case (adr_i)
      3'd0:    rdat_o = design_id[15:8];
      3'd1:    rdat_o = design_id[7:0];
      3'd2:    rdat_o = `REV_MAJOR;
      3'd3:    rdat_o = `REV_MINOR;
      3'd4:    rdat_o = `REV_RCS;
      3'd5:    rdat_o = {4'b0000, irq_status};
      3'd6:    rdat_o = {4'b0000, irq_mask};
      default: rdat_o = scratch;
    endcase
  end

endmodule

//--- tests/board_ctrl_tb.sv
`timescale 1ns/100ps
`include "board_ctrl_macros.svh"

module board_ctrl_tb
  import board_bus_pkg::*, board_io_pkg::*;
();

  localparam int reset_cycles  = 16;
  localparam int rdy_limit     = 32;
  // register accesses made outside the tables, used to size the watchdog
  localparam int directed_ops  = 15;
  localparam logic [15:0] id_word = `DESIGN_ID;
  localparam strap_t straps_val   = 8'h96;
  localparam dip_t   user_dip_val = 4'ha;
  localparam dip_t   cfg_dip_val  = 4'h5;

  typedef struct packed {
    logic      wr;
    epb_addr_t addr;
    bus_data_t wdat;
    bus_data_t expd;
    logic      chk;
  } bus_op_t;

  typedef struct packed {
    dip_t       cdip;
    strap_t     straps;
    dip_t       udip;
    boot_conf_t boot;
    logic       wp;
  } boot_case_t;

  logic       clk_master;
  logic       sys_reset;
  logic       epb_cs_n;
  logic       epb_oe_n;
  logic       epb_we_n;
  epb_addr_t  epb_addr;
  bus_data_t  epb_wdata;
  irq_vec_t   irq_src;
  strap_t     sys_config;
  dip_t       user_dip;
  dip_t       config_dip;
  logic       flash_busy_n;
  logic       reset_debug_n;
  bus_data_t  epb_data_o;
  logic       epb_data_oe_o;
  logic       epb_rdy_o;
  logic       ppc_irq_n_o;
  led_t       user_led_n_o;
  logic       ppc_reset_n_o;
  logic       ppc_ddr2_reset_n_o;
  logic       geth_reset_n_o;
  logic       por_force_oe_o;
  boot_conf_t boot_conf_o;
  logic       eeprom_wp_o;

  bus_op_t    ops[$];
  boot_case_t boot_cases[$];
  int         err_count    = 0;
  int         proto_count  = 0;
  logic       tables_built = 1'b0;

  board_ctrl_top dut0 (
    .clk_master         (clk_master),
    .sys_reset          (sys_reset),
    .epb_cs_n_i         (epb_cs_n),
    .epb_oe_n_i         (epb_oe_n),
    .epb_we_n_i         (epb_we_n),
    .epb_addr_i         (epb_addr),
    .epb_data_i         (epb_wdata),
    .epb_data_o         (epb_data_o),
    .epb_data_oe_o      (epb_data_oe_o),
    .epb_rdy_o          (epb_rdy_o),
    .irq_src_i          (irq_src),
    .ppc_irq_n_o        (ppc_irq_n_o),
    .sys_config_i       (sys_config),
    .user_dip_i         (user_dip),
    .config_dip_i       (config_dip),
    .flash_busy_n_i     (flash_busy_n),
    .reset_debug_n_i    (reset_debug_n),
    .user_led_n_o       (user_led_n_o),
    .ppc_reset_n_o      (ppc_reset_n_o),
    .ppc_ddr2_reset_n_o (ppc_ddr2_reset_n_o),
    .geth_reset_n_o     (geth_reset_n_o),
    .por_force_oe_o     (por_force_oe_o),
    .boot_conf_o        (boot_conf_o),
    .eeprom_wp_o        (eeprom_wp_o)
  );

  initial begin
    clk_master = 1'b0;
    forever #20 clk_master = ~clk_master;
  end

  // **************************************************
  // compare tasks
  // **************************************************

  task automatic check_data(input string name, input bus_data_t expd, input bus_data_t act);
    if (act !== expd) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expd, act);
      err_count++;
    end
  endtask

  task automatic check_boot(input string name, input boot_conf_t expd, input boot_conf_t act);
    if (act !== expd) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expd, act);
      err_count++;
    end
  endtask

  task automatic check_led(input string name, input led_t expd, input led_t act);
    if (act !== expd) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expd, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expd, input logic act);
    if (act !== expd) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expd, act);
      err_count++;
    end
  endtask

  // **************************************************
  // epb host
  // **************************************************

  function automatic epb_addr_t sys_addr(input reg_addr_t idx);
    return {2'b11, idx};
  endfunction

  function automatic epb_addr_t misc_addr(input reg_addr_t idx);
    return {2'b00, idx};
  endfunction

  // outputs are sampled on the clock edge, before the DUT's own updates land
  task automatic epb_access(input logic write, input epb_addr_t addr, input bus_data_t wdata,
                            output bus_data_t rdata);
    int cycles;
    cycles = 0;
    rdata = 8'h00;
    @(posedge clk_master);
    epb_cs_n  <= 1'b0;
    epb_we_n  <= !write;
    epb_oe_n  <= write;
    epb_addr  <= addr;
    epb_wdata <= wdata;
    do begin
      @(posedge clk_master);
      cycles++;
    end while (!epb_rdy_o && cycles < rdy_limit);
    if (!epb_rdy_o) begin
      $display("epb access to address %h got no ready within %0d cycles", addr, rdy_limit);
      proto_count++;
    end else begin
      rdata = epb_data_o;
      check_bit("epb_data_oe_o", !write, epb_data_oe_o);
      // chip select is still held so ready has to stay up
      @(posedge clk_master);
      check_bit("epb_rdy_o", 1'b1, epb_rdy_o);
    end
    epb_cs_n <= 1'b1;
    epb_we_n <= 1'b1;
    epb_oe_n <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_master);
      cycles++;
    end while (epb_rdy_o && cycles < rdy_limit);
    if (epb_rdy_o) begin
      $display("epb ready stayed high after chip select was released at address %h", addr);
      proto_count++;
    end
    check_bit("epb_data_oe_o", 1'b0, epb_data_oe_o);
  endtask

  task automatic write_reg(input epb_addr_t addr, input bus_data_t wdata);
    bus_data_t unused_rdata;
    epb_access(1'b1, addr, wdata, unused_rdata);
  endtask

  task automatic read_expect(input epb_addr_t addr, input bus_data_t expd);
    bus_data_t rdata;
    epb_access(1'b0, addr, 8'h00, rdata);
    check_data($sformatf("epb_data_o[addr %h]", addr), expd, rdata);
  endtask

  // **************************************************
  // stimulus tables
  // **************************************************

  task automatic add_op(input logic wr, input epb_addr_t addr, input bus_data_t wdat,
                        input bus_data_t expd, input logic chk);
    bus_op_t op;
    op.wr   = wr;
    op.addr = addr;
    op.wdat = wdat;
    op.expd = expd;
    op.chk  = chk;
    ops.push_back(op);
  endtask

  task automatic add_boot(input dip_t cdip, input strap_t straps, input dip_t udip,
                          input boot_conf_t boot, input logic wp);
    boot_case_t bc;
    bc.cdip   = cdip;
    bc.straps = straps;
    bc.udip   = udip;
    bc.boot   = boot;
    bc.wp     = wp;
    boot_cases.push_back(bc);
  endtask

  task automatic build_tables(input bus_data_t scratch, input led_t led);
    add_op(1'b0, sys_addr(3'd0), 8'h00, id_word[15:8], 1'b1);
    add_op(1'b0, sys_addr(3'd1), 8'h00, id_word[7:0], 1'b1);
    add_op(1'b0, sys_addr(3'd2), 8'h00, `REV_MAJOR, 1'b1);
    add_op(1'b0, sys_addr(3'd3), 8'h00, `REV_MINOR, 1'b1);
    add_op(1'b0, sys_addr(3'd4), 8'h00, `REV_RCS, 1'b1);
    add_op(1'b1, sys_addr(3'd7), scratch, 8'h00, 1'b0);
    add_op(1'b0, sys_addr(3'd7), 8'h00, scratch, 1'b1);
    add_op(1'b1, misc_addr(3'd2), {6'b000000, led}, 8'h00, 1'b0);
    add_op(1'b0, misc_addr(3'd2), 8'h00, {6'b000000, led}, 1'b1);
    add_op(1'b0, misc_addr(3'd3), 8'h00, straps_val, 1'b1);
    add_op(1'b0, misc_addr(3'd4), 8'h00, {user_dip_val, cfg_dip_val}, 1'b1);
    add_op(1'b0, misc_addr(3'd5), 8'h00, 8'h01, 1'b1);
    add_op(1'b0, misc_addr(3'd6), 8'h00, 8'h00, 1'b1);
    // the unmapped windows share register indexes with both slaves
    add_op(1'b1, 5'h0f, ~scratch, 8'h00, 1'b0);
    add_op(1'b0, 5'h0f, 8'h00, 8'h00, 1'b1);
    add_op(1'b1, 5'h12, ~{6'b000000, led}, 8'h00, 1'b0);
    add_op(1'b0, 5'h12, 8'h00, 8'h00, 1'b1);
    add_op(1'b0, 5'h10, 8'h00, 8'h00, 1'b1);
    add_op(1'b0, sys_addr(3'd7), 8'h00, scratch, 1'b1);
    add_op(1'b0, misc_addr(3'd2), 8'h00, {6'b000000, led}, 1'b1);
    add_boot(4'b0000, 8'h00, 4'h0, 3'b001, 1'b1);
    add_boot(4'b0101, 8'hff, 4'h8, 3'b001, 1'b0);
    add_boot(4'b0010, 8'h02, 4'h7, 3'b010, 1'b1);
    add_boot(4'b1110, 8'hff, 4'hf, 3'b010, 1'b0);
    add_boot(4'b0011, 8'h02, 4'h0, 3'b111, 1'b1);
    add_boot(4'b1111, 8'hfe, 4'h8, 3'b111, 1'b0);
    add_boot(4'b0011, 8'h00, 4'h1, 3'b010, 1'b1);
    add_boot(4'b1011, 8'hfd, 4'hc, 3'b010, 1'b0);
  endtask

  task automatic run_bus_table();
    bus_data_t rdata;
    foreach (ops[i]) begin
      epb_access(ops[i].wr, ops[i].addr, ops[i].wdat, rdata);
      if (ops[i].chk) begin
        check_data($sformatf("epb_data_o[addr %h]", ops[i].addr), ops[i].expd, rdata);
      end
    end
  endtask

  task automatic run_boot_table();
    foreach (boot_cases[i]) begin
      @(posedge clk_master);
      config_dip <= boot_cases[i].cdip;
      sys_config <= boot_cases[i].straps;
      user_dip   <= boot_cases[i].udip;
      repeat (2) @(posedge clk_master);
      check_boot("boot_conf_o", boot_cases[i].boot, boot_conf_o);
      check_bit("eeprom_wp_o", boot_cases[i].wp, eeprom_wp_o);
    end
  endtask

  // mask enables sources 0 and 2, source 1 stays masked out
  task automatic run_irq_checks();
    write_reg(sys_addr(3'd6), 8'hf5);
    read_expect(sys_addr(3'd6), 8'h05);
    @(posedge clk_master);
    irq_src <= 4'b0010;
    repeat (3) @(posedge clk_master);
    check_bit("ppc_irq_n_o", 1'b1, ppc_irq_n_o);
    read_expect(sys_addr(3'd5), 8'h02);
    @(posedge clk_master);
    irq_src <= 4'b0110;
    repeat (3) @(posedge clk_master);
    check_bit("ppc_irq_n_o", 1'b0, ppc_irq_n_o);
    read_expect(sys_addr(3'd5), 8'h06);
    write_reg(sys_addr(3'd5), 8'h04);
    read_expect(sys_addr(3'd5), 8'h02);
    check_bit("ppc_irq_n_o", 1'b1, ppc_irq_n_o);
    write_reg(sys_addr(3'd5), 8'hff);
    read_expect(sys_addr(3'd5), 8'h00);
    @(posedge clk_master);
    irq_src <= 4'b0000;
  endtask

  task automatic run_reset_checks();
    check_bit("por_force_oe_o", 1'b0, por_force_oe_o);
    write_reg(misc_addr(3'd0), 8'h01);
    check_bit("por_force_oe_o", 1'b1, por_force_oe_o);
    write_reg(misc_addr(3'd0), 8'h00);
    read_expect(misc_addr(3'd0), 8'h00);
    check_bit("por_force_oe_o", 1'b1, por_force_oe_o);
    write_reg(misc_addr(3'd1), 8'h01);
    read_expect(misc_addr(3'd1), 8'h01);
    check_bit("geth_reset_n_o", 1'b0, geth_reset_n_o);
    check_bit("ppc_ddr2_reset_n_o", 1'b1, ppc_ddr2_reset_n_o);
    write_reg(misc_addr(3'd1), 8'h00);
    check_bit("geth_reset_n_o", 1'b1, geth_reset_n_o);
    @(posedge clk_master);
    reset_debug_n <= 1'b0;
    repeat (2) @(posedge clk_master);
    check_bit("ppc_reset_n_o", 1'b0, ppc_reset_n_o);
    check_bit("ppc_ddr2_reset_n_o", 1'b1, ppc_ddr2_reset_n_o);
    reset_debug_n <= 1'b1;
    repeat (2) @(posedge clk_master);
    check_bit("ppc_reset_n_o", 1'b1, ppc_reset_n_o);
    // a second system reset is the only way to drop the por force
    sys_reset <= 1'b1;
    repeat (reset_cycles) @(posedge clk_master);
    check_bit("ppc_ddr2_reset_n_o", 1'b0, ppc_ddr2_reset_n_o);
    check_bit("ppc_reset_n_o", 1'b0, ppc_reset_n_o);
    sys_reset <= 1'b0;
    repeat (2) @(posedge clk_master);
    check_bit("por_force_oe_o", 1'b0, por_force_oe_o);
    check_bit("ppc_ddr2_reset_n_o", 1'b1, ppc_ddr2_reset_n_o);
    check_led("user_led_n_o", 2'b11, user_led_n_o);
  endtask

  // **************************************************
  // main sequence and watchdog
  // **************************************************

  initial begin
    logic [31:0] rnd;
    bus_data_t   scratch_val;
    led_t        led_val;
    sys_reset     = 1'b1;
    epb_cs_n      = 1'b1;
    epb_oe_n      = 1'b1;
    epb_we_n      = 1'b1;
    epb_addr      = 5'h00;
    epb_wdata     = 8'h00;
    irq_src       = 4'h0;
    sys_config    = straps_val;
    user_dip      = user_dip_val;
    config_dip    = cfg_dip_val;
    flash_busy_n  = 1'b1;
    reset_debug_n = 1'b1;
    void'($urandom(90));
    rnd = $urandom();
    scratch_val = rnd[7:0];
    led_val = rnd[9:8];
    // keep at least one led lit so the written value differs from the reset value
    if (led_val == 2'b00) begin
      led_val = 2'b01;
    end
    build_tables(scratch_val, led_val);
    tables_built = 1'b1;
    repeat (reset_cycles) @(posedge clk_master);
    sys_reset <= 1'b0;
    run_bus_table();
    check_led("user_led_n_o", ~led_val, user_led_n_o);
    @(posedge clk_master);
    flash_busy_n <= 1'b0;
    read_expect(misc_addr(3'd5), 8'h00);
    run_irq_checks();
    run_reset_checks();
    run_boot_table();
    $display("summary: %0d value errors, %0d bus protocol errors", err_count, proto_count);
    if (err_count == 0 && proto_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (tables_built);
    limit = (ops.size() + boot_cases.size() + directed_ops) * 20 + 3 * reset_cycles;
    repeat (limit) @(posedge clk_master);
    $display("watchdog expired after %0d cycles, the tests did not finish", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
